/* verilog/cuPkg.sv */
`default_nettype none

package cuPkg;

	typedef logic [7:0] insT;

	// Opcodes as stored in instruction memory
	localparam insT opRstAll  = 8'h01;
	localparam insT opRstAc   = 8'h02;
	localparam insT opRstAddr = 8'h03;
	localparam insT opRstGsp  = 8'h04;
	localparam insT opRstMc   = 8'h05;
	localparam insT opRstCp   = 8'h06;
	localparam insT opRstRp   = 8'h07;
	localparam insT opIncGsp  = 8'h08;
	localparam insT opIncAc   = 8'h09;
	localparam insT opIncCp   = 8'h0a;
	localparam insT opIncRp   = 8'h0b;
	localparam insT opIncMc   = 8'h0c;
	localparam insT opIncStp  = 8'h0d;
	localparam insT opLdAddr  = 8'h10;
	localparam insT opLdAc    = 8'h11;
	localparam insT opLdMulr  = 8'h12;
	localparam insT opLdRp    = 8'h13;
	localparam insT opLdCp    = 8'h14;
	localparam insT opStSp    = 8'h15;
	localparam insT opAdd     = 8'h20;
	localparam insT opMul1    = 8'h21;
	localparam insT opMul2    = 8'h22;
	localparam insT opDiv     = 8'h23;
	localparam insT opMod     = 8'h24;
	localparam insT opJmp     = 8'h30;
	localparam insT opJz1     = 8'h31;
	localparam insT opHalt    = 8'hff;

	// Entry states share the opcode value, so dispatch is a plain load
	typedef enum logic [7:0] {
		stRstAll = opRstAll, stRstAc = opRstAc, stRstAddr = opRstAddr,
		stRstGsp = opRstGsp, stRstMc = opRstMc, stRstCp = opRstCp, stRstRp = opRstRp,
		stIncGsp = opIncGsp, stIncAc = opIncAc, stIncCp = opIncCp,
		stIncRp = opIncRp, stIncMc = opIncMc, stIncStp = opIncStp,
		stLdAddr = opLdAddr, stLdAc = opLdAc, stLdMulr = opLdMulr,
		stLdRp = opLdRp, stLdCp = opLdCp, stStSp = opStSp,
		stAdd = opAdd, stMul1 = opMul1, stMul2 = opMul2, stDiv = opDiv, stMod = opMod,
		stJmp = opJmp, stJz1 = opJz1, stHalt = opHalt,
		stFetch1 = 8'h80, stFetch2 = 8'h81,
		stLdAddr2 = 8'h90, stLdAc2 = 8'h91, stLdMulr2 = 8'h92,
		stLdRp2 = 8'h93, stLdCp2 = 8'h94,
		stJmpWait = 8'ha0, stJmp2 = 8'ha1, stJmp3 = 8'ha2, stJmp4 = 8'ha3,
		stJz1Wait = 8'hb0, stJz1Taken1 = 8'hb1, stJz1Taken2 = 8'hb2,
		stJz1Taken3 = 8'hb3, stJz1Skip1 = 8'hb4, stJz1Skip2 = 8'hb5
	} stateT;

	typedef enum logic [2:0] {
		aluNone, aluAdd, aluMul, aluDiv, aluMod
	} aluOpT;

	typedef enum logic [3:0] {
		busMemOut, busAc, busAddr, busMulr, busMv, busWv
	} busSelT;

	typedef enum logic [1:0] {
		ptrGsp, ptrRp, ptrCp, ptrStp
	} pCtrlT;

	typedef enum logic [3:0] {
		memIdle, memIRead, memRead, memWrite
	} memCtrlT;

	localparam int numRegs = 14;
	typedef logic [numRegs-1:0] regMaskT;

	// Datapath register positions in the masks
	localparam int regPc   = 0;
	localparam int regIr   = 1;
	localparam int regGsp  = 2;
	localparam int regRp   = 3;
	localparam int regCp   = 4;
	localparam int regStp  = 5;
	localparam int regCid  = 6;
	localparam int regEopc = 7;
	localparam int regMc   = 8;
	localparam int regMv   = 9;
	localparam int regWv   = 10;
	localparam int regMulr = 11;
	localparam int regAddr = 12;
	localparam int regAc   = 13;

	// Everything above IR, PC and IR survive a clear-all
	localparam regMaskT rstAllMask = regMaskT'({(numRegs - regGsp){1'b1}}) << regGsp;

endpackage

`default_nettype wire

/* verilog/cuSequencer.sv */
`default_nettype none

module cuSequencer (
	input logic clk,
	input logic arstN,
	input cuPkg::insT ins,
	input logic z1,
	input logic acq,
	input logic iacq,
	output cuPkg::stateT state
);
	import cuPkg::*;

	stateT nextState;
	insT insReg;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stFetch1;
		end else begin
			state <= nextState;
		end
	end

	// Instruction byte taken with the fetch acknowledge
	always_ff @(posedge clk) begin
		if (state == stFetch1 && iacq) begin
			insReg <= ins;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stFetch1: begin
				if (iacq) begin
					nextState = stFetch2;
				end
			end
			stFetch2: begin
				case (insReg)
					opRstAll, opRstAc, opRstAddr, opRstGsp, opRstMc, opRstCp, opRstRp,
					opIncGsp, opIncAc, opIncCp, opIncRp, opIncMc, opIncStp,
					opLdAddr, opLdAc, opLdMulr, opLdRp, opLdCp, opStSp,
					opAdd, opMul1, opMul2, opDiv, opMod,
					opJmp, opJz1, opHalt: begin
						nextState = stateT'(insReg);
					end
					default: begin
						nextState = stHalt;
					end
				endcase
			end
			// Single cycle instructions
			stRstAll, stRstAc, stRstAddr, stRstGsp, stRstMc, stRstCp, stRstRp,
			stIncGsp, stIncAc, stIncCp, stIncRp, stIncMc, stIncStp,
			stAdd, stMul1, stMul2, stDiv, stMod: begin
				nextState = stFetch1;
			end
			stLdAddr: begin
				if (acq) begin
					nextState = stLdAddr2;
				end
			end
			stLdAc: begin
				if (acq) begin
					nextState = stLdAc2;
				end
			end
			stLdMulr: begin
				if (acq) begin
					nextState = stLdMulr2;
				end
			end
			stLdRp: begin
				if (acq) begin
					nextState = stLdRp2;
				end
			end
			stLdCp: begin
				if (acq) begin
					nextState = stLdCp2;
				end
			end
			stLdAddr2, stLdAc2, stLdMulr2, stLdRp2, stLdCp2: begin
				nextState = stFetch1;
			end
			stStSp: begin
				if (acq) begin
					nextState = stFetch1;
				end
			end
			stJmp:  nextState = stJmpWait;
			stJmpWait: begin
				if (iacq) begin
					nextState = stJmp2;
				end
			end
			stJmp2: nextState = stJmp3;
			stJmp3: nextState = stJmp4;
			stJmp4: nextState = stFetch1;
			stJz1:  nextState = stJz1Wait;
			// Branch direction decided by z1 at the acknowledge
			stJz1Wait: begin
				if (iacq) begin
					nextState = z1 ? stJz1Taken1 : stJz1Skip1;
				end
			end
			stJz1Taken1: nextState = stJz1Taken2;
			stJz1Taken2: nextState = stJz1Taken3;
			stJz1Taken3: nextState = stFetch1;
			stJz1Skip1:  nextState = stJz1Skip2;
			stJz1Skip2:  nextState = stFetch1;
			stHalt:      nextState = stHalt;
			default:     nextState = stHalt;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/cuControlDecode.sv */
`default_nettype none

module cuControlDecode (
	input cuPkg::stateT state,
	output cuPkg::aluOpT aluOp,
	output cuPkg::busSelT busSel,
	output cuPkg::pCtrlT pCtrl,
	output cuPkg::memCtrlT memCtrl,
	output cuPkg::regMaskT writeEn,
	output cuPkg::regMaskT incEn,
	output cuPkg::regMaskT rstEn
);
	import cuPkg::*;

	always_comb begin
		// Idle control word
		aluOp = aluNone;
		busSel = busAc;
		pCtrl = ptrGsp;
		memCtrl = memIdle;
		writeEn = '0;
		incEn = '0;
		rstEn = '0;

		case (state)
			stFetch1: memCtrl = memIRead;
			stFetch2: begin
				writeEn[regIr] = 1'b1;
				incEn[regPc] = 1'b1;
			end

			stRstAll:  rstEn = rstAllMask;
			stRstAc:   rstEn[regAc] = 1'b1;
			stRstAddr: rstEn[regAddr] = 1'b1;
			stRstGsp:  rstEn[regGsp] = 1'b1;
			stRstMc:   rstEn[regMc] = 1'b1;
			stRstCp:   rstEn[regCp] = 1'b1;
			stRstRp:   rstEn[regRp] = 1'b1;

			stIncGsp: incEn[regGsp] = 1'b1;
			stIncAc:  incEn[regAc] = 1'b1;
			stIncCp:  incEn[regCp] = 1'b1;
			stIncRp:  incEn[regRp] = 1'b1;
			stIncMc:  incEn[regMc] = 1'b1;
			stIncStp: incEn[regStp] = 1'b1;

			// Load requests, RP and CP address through their own pointer
			stLdAddr, stLdAc, stLdMulr: memCtrl = memRead;
			stLdRp: begin
				memCtrl = memRead;
				pCtrl = ptrRp;
			end
			stLdCp: begin
				memCtrl = memRead;
				pCtrl = ptrCp;
			end
			stLdAddr2: begin
				busSel = busMemOut;
				writeEn[regAddr] = 1'b1;
			end
			stLdAc2: begin
				busSel = busMemOut;
				writeEn[regAc] = 1'b1;
			end
			stLdMulr2: begin
				busSel = busMemOut;
				writeEn[regMulr] = 1'b1;
			end
			stLdRp2: begin
				busSel = busMemOut;
				writeEn[regRp] = 1'b1;
			end
			stLdCp2: begin
				busSel = busMemOut;
				writeEn[regCp] = 1'b1;
			end

			stStSp: begin
				memCtrl = memWrite;
				pCtrl = ptrStp;
			end

			stAdd: begin
				aluOp = aluAdd;
				busSel = busAddr;
			end
			stMul1: begin
				aluOp = aluMul;
				busSel = busMulr;
			end
			stMul2: begin
				aluOp = aluMul;
				busSel = busMv;
			end
			stDiv: begin
				aluOp = aluDiv;
				busSel = busWv;
			end
			stMod: begin
				aluOp = aluMod;
				busSel = busWv;
			end

			// Target address word comes through the instruction port
			stJmpWait: memCtrl = memIRead;
			stJmp3:    writeEn[regPc] = 1'b1;

			stJz1Wait:   memCtrl = memIRead;
			stJz1Taken1: writeEn[regIr] = 1'b1;
			stJz1Taken2: writeEn[regPc] = 1'b1;
			stJz1Skip1: begin
				writeEn[regIr] = 1'b1;
				incEn[regPc] = 1'b1;
			end

			// Halt, entry and tail states keep the idle word
			default: begin
				memCtrl = memIdle;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/cuTop.sv */
`default_nettype none

module cuTop (
	input logic clk,
	input logic arstN,
	input cuPkg::insT ins,
	input logic z1,
	input logic acq,
	input logic iacq,
	output cuPkg::aluOpT aluOp,
	output cuPkg::busSelT busSel,
	output cuPkg::pCtrlT pCtrl,
	output cuPkg::memCtrlT memCtrl,
	output cuPkg::regMaskT writeEn,
	output cuPkg::regMaskT incEn,
	output cuPkg::regMaskT rstEn
);
	import cuPkg::*;

	stateT state;

	cuSequencer i_sequencer (
		.clk   (clk),
		.arstN (arstN),
		.ins   (ins),
		.z1    (z1),
		.acq   (acq),
		.iacq  (iacq),
		.state (state)
	);

	// Control word follows the current state
	cuControlDecode i_decode (
		.state   (state),
		.aluOp   (aluOp),
		.busSel  (busSel),
		.pCtrl   (pCtrl),
		.memCtrl (memCtrl),
		.writeEn (writeEn),
		.incEn   (incEn),
		.rstEn   (rstEn)
	);

endmodule

`default_nettype wire

/* tb/cuChk_chk.sv */
`default_nettype none

module cuChk (
	input logic clk,
	input logic arstN,
	input logic acq,
	input logic iacq,
	input cuPkg::memCtrlT memCtrl,
	input cuPkg::regMaskT writeEn,
	input cuPkg::regMaskT incEn,
	input cuPkg::regMaskT rstEn
);
	timeunit 1ns;
	timeprecision 100ps;
	import cuPkg::*;

	// A register is either stepped or cleared, never both
	noIncAndClear: assert property (@(posedge clk) disable iff (!arstN)
		(incEn & rstEn) == '0)
		else $error("incEn and rstEn share a set bit");

	idleAfterIack: assert property (@(posedge clk) disable iff (!arstN)
		iacq |=> memCtrl == memIdle)
		else $error("memCtrl not idle after iacq");

	idleAfterRead: assert property (@(posedge clk) disable iff (!arstN)
		(acq && memCtrl == memRead) |=> memCtrl == memIdle)
		else $error("memCtrl not idle after read acq");

	// Store goes straight back to the fetch
	fetchAfterWrite: assert property (@(posedge clk) disable iff (!arstN)
		(acq && memCtrl == memWrite) |=> memCtrl == memIRead)
		else $error("no fetch request after write acq");

	noMaskInRequest: assert property (@(posedge clk) disable iff (!arstN)
		memCtrl != memIdle |-> (writeEn | incEn | rstEn) == '0)
		else $error("mask bit set during a memory request");

endmodule

bind cuTop cuChk i_chk (
	.clk     (clk),
	.arstN   (arstN),
	.acq     (acq),
	.iacq    (iacq),
	.memCtrl (memCtrl),
	.writeEn (writeEn),
	.incEn   (incEn),
	.rstEn   (rstEn)
);

`default_nettype wire

/* tb/cuTb.sv */
`default_nettype none

module cuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cuPkg::*;

	localparam int fieldsPerRec = 9;
	localparam int fetchLimit = 20;
	localparam int instLimit = 60;
	localparam int haltCycles = 20;

	logic clk;
	logic arstN;
	insT ins;
	logic z1;
	logic acq;
	logic iacq;
	aluOpT aluOp;
	busSelT busSel;
	pCtrlT pCtrl;
	memCtrlT memCtrl;
	regMaskT writeEn;
	regMaskT incEn;
	regMaskT rstEn;

	logic [15:0] stim [0:511];
	integer seed = 12931;
	logic memOn;
	logic armed;
	int delayLeft;

	cuTop i_dut (
		.clk     (clk),
		.arstN   (arstN),
		.ins     (ins),
		.z1      (z1),
		.acq     (acq),
		.iacq    (iacq),
		.aluOp   (aluOp),
		.busSel  (busSel),
		.pCtrl   (pCtrl),
		.memCtrl (memCtrl),
		.writeEn (writeEn),
		.incEn   (incEn),
		.rstEn   (rstEn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abortRun();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout: %s", what);
		abortRun();
	endtask

	task automatic checkMask(input string name, input regMaskT got, input regMaskT exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkAluOp(input string name, input aluOpT got, input aluOpT exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
			abortRun();
		end
	endtask

	task automatic checkBusSel(input string name, input busSelT got, input busSelT exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
			abortRun();
		end
	endtask

	task automatic checkPtr(input string name, input pCtrlT got, input pCtrlT exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
			abortRun();
		end
	endtask

	task automatic checkMem(input string name, input memCtrlT got, input memCtrlT exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
			abortRun();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	// One strobe per request run, after 0 to 3 wait cycles
	task automatic serveMemory();
		acq = 1'b0;
		iacq = 1'b0;
		if (!memOn || memCtrl == memIdle) begin
			armed = 1'b0;
		end else begin
			if (!armed) begin
				delayLeft = {$random(seed)} % 4;
				armed = 1'b1;
			end
			if (delayLeft == 0) begin
				if (memCtrl == memIRead) begin
					iacq = 1'b1;
				end else begin
					acq = 1'b1;
				end
				armed = 1'b0;
			end else begin
				delayLeft--;
			end
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#5;
		serveMemory();
	endtask

	task automatic applyReset();
		memOn = 1'b0;
		armed = 1'b0;
		arstN = 1'b0;
		repeat (10) nextCycle();
		arstN = 1'b1;
		// Fetch request is up before any acknowledge
		checkMem("memCtrl", memCtrl, memIRead);
		checkMask("writeEn", writeEn, regMaskT'(0));
		checkMask("incEn", incEn, regMaskT'(0));
		checkMask("rstEn", rstEn, regMaskT'(0));
		memOn = 1'b1;
	endtask

	initial begin
		int nRec;
		int base;
		int guard;
		int runsSeen;
		int idleCount;
		int expRuns;
		bit halting;
		bit fetchSeen;
		memCtrlT prevMem;
		regMaskT wrOr;
		regMaskT incOr;
		regMaskT rstOr;
		aluOpT aluSeen;
		busSelT busSeen;

		arstN = 1'b0;
		ins = '0;
		z1 = 1'b0;
		acq = 1'b0;
		iacq = 1'b0;
		memOn = 1'b0;
		armed = 1'b0;
		delayLeft = 0;
		$readmemh("tb/cuInput.txt", stim);
		nRec = int'(stim[0]);
		applyReset();

		for (int r = 0; r < nRec; r++) begin
			base = 1 + r * fieldsPerRec;
			ins = insT'(stim[base][7:0]);
			z1 = stim[base + 1][0];
			expRuns = int'(stim[base + 8]);
			halting = (expRuns == 'hff);

			guard = 0;
			while (memCtrl == memIRead) begin
				nextCycle();
				guard++;
				if (guard > fetchLimit) begin
					reportTimeout("no instruction acknowledge ended the fetch");
				end
			end
			// Fetch2 loads IR and steps PC
			checkMask("writeEn", writeEn, regMaskT'(1 << regIr));
			checkMask("incEn", incEn, regMaskT'(1 << regPc));
			checkMask("rstEn", rstEn, regMaskT'(0));

			wrOr = '0;
			incOr = '0;
			rstOr = '0;
			aluSeen = aluNone;
			busSeen = busAc;
			idleCount = 0;
			runsSeen = 0;
			guard = 0;
			prevMem = memIdle;
			fetchSeen = 1'b0;
			while (!fetchSeen) begin
				nextCycle();
				guard++;
				if (halting) begin
					checkMem("memCtrl", memCtrl, memIdle);
				end
				if (memCtrl != memIdle && memCtrl != prevMem) begin
					runsSeen++;
				end
				if (runsSeen > expRuns) begin
					fetchSeen = 1'b1;
				end else begin
					wrOr |= writeEn;
					incOr |= incEn;
					rstOr |= rstEn;
					if (aluOp != aluNone) begin
						aluSeen = aluOp;
					end
					if (busSel != busAc) begin
						busSeen = busSel;
					end
					if (memCtrl == memIdle) begin
						idleCount++;
					end
					// Data requests: the store writes, every load reads
					if (memCtrl == memRead || memCtrl == memWrite) begin
						checkMem("memCtrl", memCtrl, (ins == opStSp) ? memWrite : memRead);
					end
					if (memCtrl == memWrite) begin
						checkPtr("pCtrl", pCtrl, ptrStp);
					end
					prevMem = memCtrl;
				end
				if (halting && guard == haltCycles) begin
					fetchSeen = 1'b1;
				end
				if (guard > instLimit) begin
					reportTimeout("instruction never returned to fetch");
				end
			end

			checkMask("writeEn", wrOr, regMaskT'(stim[base + 2][13:0]));
			checkMask("incEn", incOr, regMaskT'(stim[base + 3][13:0]));
			checkMask("rstEn", rstOr, regMaskT'(stim[base + 4][13:0]));
			checkAluOp("aluOp", aluSeen, aluOpT'(stim[base + 5][2:0]));
			checkBusSel("busSel", busSeen, busSelT'(stim[base + 6][3:0]));
			checkCount("non-wait cycles", idleCount, int'(stim[base + 7]));

			// Halt only leaves through reset
			if (halting && r < nRec - 1) begin
				applyReset();
			end
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/cuInput.txt */
// First word: record count. Then one record per line, all hex:
// opcode z1 writeEn incEn rstEn aluOp busSel nonWaitCycles requestRuns (ff = halts)
1d
01 0 0000 0000 3ffc 0 1 1 0
02 0 0000 0000 2000 0 1 1 0
03 0 0000 0000 1000 0 1 1 0
04 0 0000 0000 0004 0 1 1 0
05 0 0000 0000 0100 0 1 1 0
06 0 0000 0000 0010 0 1 1 0
07 0 0000 0000 0008 0 1 1 0
08 0 0000 0004 0000 0 1 1 0
09 0 0000 2000 0000 0 1 1 0
0a 0 0000 0010 0000 0 1 1 0
0b 0 0000 0008 0000 0 1 1 0
0c 0 0000 0100 0000 0 1 1 0
0d 0 0000 0020 0000 0 1 1 0
10 0 1000 0000 0000 0 0 1 1
11 0 2000 0000 0000 0 0 1 1
12 0 0800 0000 0000 0 0 1 1
13 0 0008 0000 0000 0 0 1 1
14 0 0010 0000 0000 0 0 1 1
15 0 0000 0000 0000 0 1 0 1
20 0 0000 0000 0000 1 2 1 0
21 0 0000 0000 0000 2 3 1 0
22 0 0000 0000 0000 2 4 1 0
23 0 0000 0000 0000 3 5 1 0
24 0 0000 0000 0000 4 5 1 0
30 0 0001 0000 0000 0 1 4 1
31 1 0003 0000 0000 0 1 4 1
31 0 0002 0001 0000 0 1 3 1
77 0 0000 0000 0000 0 1 14 ff
ff 0 0000 0000 0000 0 1 14 ff

/* src.f */
verilog/cuPkg.sv
verilog/cuSequencer.sv
verilog/cuControlDecode.sv
verilog/cuTop.sv
tb/cuChk_chk.sv
tb/cuTb.sv

/* Makefile */
SIM      := verilator
TOP      := cuTb
FILELIST := src.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
